//--- dv/tomasulo_core_asserts.sv
`timescale 1ns/1ps

module tomasulo_core_asserts #(
	parameter int queue_depth = 4,
	parameter int num_stations = 3
)
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic credit_return,
	input logic issue_fire,
	input logic commit_valid,
	input lc3b_types::cdb_t cdb,
	input logic [num_stations-1:0] station_busy
);
	import lc3b_types::*;

	int accepted;
	int returned;
	int occupancy;   // Words in the queue, mirrored from the boundary
	int in_stations;   // Issued ops not yet broadcast

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			accepted <= 0;
			returned <= 0;
			occupancy <= 0;
			in_stations <= 0;
		end
		else
		begin
			accepted <= accepted + int'(instr_valid);
			returned <= returned + int'(credit_return);
			occupancy <= occupancy + int'(instr_valid) - int'(issue_fire);
			in_stations <= in_stations + int'(issue_fire) - int'(cdb.valid);
		end
	end

	credit_bound: assert property (@(posedge clk) disable iff (rst)
		credit_return |-> returned < accepted)
		else $error("credit returned for a word that was never accepted");

	no_overfill: assert property (@(posedge clk) disable iff (rst)
		instr_valid |-> occupancy < queue_depth)
		else $error("instruction offered while the queue had no free slot");

	commit_quiet_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !commit_valid)
		else $error("commit_valid high during reset");

	// The broadcasting station held an issued op and was freed with the broadcast
	cdb_from_busy: assert property (@(posedge clk) disable iff (rst)
		cdb.valid |-> in_stations > 0 && $countones(station_busy) == in_stations - 1)
		else $error("CDB broadcast from a station that held no issued operation");

endmodule : tomasulo_core_asserts

bind tomasulo_core tomasulo_core_asserts #(
	.queue_depth(queue_depth),
	.num_stations(num_stations)
) tomasulo_core_asserts_inst (.*);

//--- dv/tomasulo_core_tb.sv
`timescale 1ns/1ps

module tomasulo_core_tb;
	import lc3b_types::*;

	localparam int queue_depth = 4;
	localparam int num_stations = 3;
	localparam int wait_limit = 400;   // Cycles per wait

	logic clk;
	logic rst;
	logic instr_valid;
	lc3b_word instr;
	logic credit_return;
	logic commit_valid;
	commit_t commit;

	lc3b_word model_regs [8];   // Architectural state in program order
	commit_t expected_q [$];
	int seed = 32'h2f75_f040;
	int sent_count;
	int credit_count;
	int commit_count;
	int max_outstanding;
	int checks;
	int errors;
	bit timed_out;

	tomasulo_core #(.queue_depth(queue_depth), .num_stations(num_stations)) tomasulo_core_inst
	(
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.credit_return(credit_return),
		.commit_valid(commit_valid),
		.commit(commit)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Registered outputs, settled by the falling edge
	always @(negedge clk)
	begin
		if (!rst && credit_return)
			credit_count++;
		if (!rst && commit_valid)
		begin
			commit_count++;
			checks++;
			assert (expected_q.size() != 0)
			else
			begin
				errors++;
				$display("A commit arrived while no instruction was outstanding");
			end
			if (expected_q.size() != 0)
			begin
				checks++;
				assert (commit == expected_q[0])
				else
				begin
					errors++;
					$display("[ERROR] %0t: commit r%0d = %h, expected r%0d = %h", $time,
						commit.dest, commit.value, expected_q[0].dest, expected_q[0].value);
				end
				void'(expected_q.pop_front());
			end
		end
	end

	function automatic lc3b_word encode(input lc3b_opcode op, input lc3b_reg dr,
		input lc3b_reg sr1, input logic use_imm, input logic [4:0] low);
		return {op, dr, sr1, use_imm, low};
	endfunction

	// Result of one instruction against the model registers
	function automatic lc3b_word model_exec(input lc3b_word w);
		lc3b_word a;
		lc3b_word b;
		a = model_regs[w[8:6]];
		if (w[5])
			b = {{11{w[4]}}, w[4:0]};
		else
			b = model_regs[w[2:0]];
		case (w[15:12])
			4'b0001: return a + b;
			4'b0101: return a & b;
			default: return ~a;
		endcase
	endfunction

	task automatic expect_equal(input int got, input int exp, input string what);
		checks++;
		assert (got == exp)
		else
		begin
			errors++;
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Called 1 ns after a rising edge, returns at the same phase
	task automatic send_word(input lc3b_word w);
		int waited;
		lc3b_word res;
		waited = 0;
		if (timed_out)
			return;
		while (sent_count - credit_count >= queue_depth && !timed_out)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit)
			begin
				timed_out = 1'b1;
				$display("Timed out waiting for a credit from the instruction queue");
			end
		end
		if (timed_out)
			return;
		instr_valid = 1'b1;
		instr = w;
		sent_count++;
		if (sent_count - credit_count > max_outstanding)
			max_outstanding = sent_count - credit_count;
		res = model_exec(w);
		model_regs[w[11:9]] = res;
		expected_q.push_back(commit_t'{dest: w[11:9], value: res});
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
	endtask

	// All commits in
	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && !timed_out)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > wait_limit)
			begin
				timed_out = 1'b1;
				$display("Timed out waiting for outstanding instructions to commit");
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s finished with %0d errors", name, errors - errors_before);
	endtask

	task automatic test_independent();
		int e0;
		e0 = errors;
		send_word(encode(op_add, 3'd1, 3'd0, 1'b1, 5'd7));
		send_word(encode(op_add, 3'd2, 3'd0, 1'b1, 5'h1e));   // -2
		send_word(encode(op_and, 3'd3, 3'd3, 1'b1, 5'd12));
		send_word(encode(op_add, 3'd4, 3'd0, 1'b1, 5'h10));
		send_word(encode(op_and, 3'd5, 3'd5, 1'b1, 5'h1f));
		wait_drain();
		report_test("independent", e0);
	endtask

	task automatic test_chain();
		int e0;
		e0 = errors;
		send_word(encode(op_add, 3'd1, 3'd0, 1'b1, 5'd5));
		send_word(encode(op_add, 3'd2, 3'd1, 1'b1, 5'd3));
		send_word(encode(op_add, 3'd3, 3'd2, 1'b0, 5'd1));   // r3 = r2 + r1
		send_word(encode(op_and, 3'd4, 3'd3, 1'b0, 5'd2));
		send_word(encode(op_not, 3'd5, 3'd4, 1'b1, 5'h1f));
		send_word(encode(op_add, 3'd6, 3'd5, 1'b0, 5'd5));
		wait_drain();
		report_test("dependent chain", e0);
	endtask

	task automatic test_random_mix();
		int e0;
		logic [31:0] r;
		e0 = errors;
		for (int i = 0; i < 40; i++)
		begin
			r = $random(seed);
			case (r[18:16])
				3'd0, 3'd1: send_word(encode(op_add, r[2:0], r[5:3], 1'b1, r[13:9]));
				3'd2, 3'd3: send_word(encode(op_add, r[2:0], r[5:3], 1'b0, {2'b00, r[8:6]}));
				3'd4: send_word(encode(op_and, r[2:0], r[5:3], 1'b1, r[13:9]));
				3'd5: send_word(encode(op_and, r[2:0], r[5:3], 1'b0, {2'b00, r[8:6]}));
				default: send_word(encode(op_not, r[2:0], r[5:3], 1'b1, 5'h1f));
			endcase
		end
		wait_drain();
		report_test("random mix", e0);
	endtask

	task automatic test_overload();
		int e0;
		e0 = errors;
		// r7 chain holds stations while independent work queues up behind it
		for (int i = 0; i < 12; i++)
		begin
			send_word(encode(op_add, 3'd7, 3'd7, 1'b0, 5'd6));
			send_word(encode(op_add, 3'(i % 7), 3'd0, 1'b1, 5'(i)));
		end
		// Read back every register through a commit
		for (int i = 0; i < 8; i++)
			send_word(encode(op_add, 3'(i), 3'(i), 1'b1, 5'd0));
		wait_drain();
		expect_equal(commit_count, sent_count, "commit count");
		report_test("overload", e0);
	endtask

	task automatic test_credits();
		int e0;
		int pulses_before;
		int sent_before;
		e0 = errors;
		pulses_before = credit_count;
		sent_before = sent_count;
		max_outstanding = 0;
		// Each word reads the one before, so stations fill and credits lag
		for (int i = 0; i < 16; i++)
			send_word(encode(op_add, 3'(i % 8), 3'((i + 7) % 8), 1'b1, 5'(i * 3)));
		wait_drain();
		expect_equal(credit_count - pulses_before, sent_count - sent_before, "credit pulses");
		expect_equal(credit_count, sent_count, "total credit pulses");
		expect_equal(max_outstanding, queue_depth, "peak outstanding words");
		report_test("credit accounting", e0);
	endtask

	initial
	begin
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		sent_count = 0;
		credit_count = 0;
		commit_count = 0;
		max_outstanding = 0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		expect_equal(int'(credit_return === 1'b0), 1, "credit_return low after reset");
		test_independent();
		test_chain();
		test_random_mix();
		test_overload();
		test_credits();
		if (timed_out)
			$display("The run ended early because a wait timed out");
		$display("Checks: %0d, errors: %0d, sent: %0d, committed: %0d",
			checks, errors, sent_count, commit_count);
		if (errors == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : tomasulo_core_tb

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tomasulo_core_tb \
	-f tomasulo_core.f -o sim_tomasulo
./obj_dir/sim_tomasulo > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- tomasulo_core.f
verilog/lc3b_types.sv
verilog/instr_queue.sv
verilog/issue_control.sv
verilog/reg_status.sv
verilog/reorder_buffer.sv
verilog/alu_station.sv
verilog/tomasulo_core.sv
dv/tomasulo_core_asserts.sv
dv/tomasulo_core_tb.sv

//--- verilog/alu_station.sv
`timescale 1ns/1ps

module alu_station #(
	parameter int num_stations = 3
)
(
	input logic clk,
	input logic rst,
	input logic rs_write,
	input logic [$clog2(num_stations)-1:0] res_station_id,
	input lc3b_types::rs_entry_t rs_entry,
	output logic [num_stations-1:0] station_busy,
	output lc3b_types::cdb_t cdb
);
	import lc3b_types::*;

	localparam int id_w = $clog2(num_stations);

	rs_entry_t ent [num_stations];
	logic sel_found;
	logic [id_w-1:0] sel_id;
	rs_entry_t sel_ent;
	lc3b_word result;
	logic cdb_valid;
	lc3b_rob_addr cdb_tag;
	lc3b_word cdb_data;

	assign cdb = '{valid: cdb_valid, tag: cdb_tag, data: cdb_data};

	// Lowest index with both operands in hand
	always_comb
	begin
		sel_found = 1'b0;
		sel_id = '0;
		for (int i = num_stations - 1; i >= 0; i--)
		begin
			if (station_busy[i] && ent[i].valid_j && ent[i].valid_k)
			begin
				sel_found = 1'b1;
				sel_id = id_w'(i);
			end
		end
	end

	assign sel_ent = ent[sel_id];

	// Shared ALU
	always_comb
	begin
		case (sel_ent.op)
			op_add: result = sel_ent.vj + sel_ent.vk;
			op_and: result = sel_ent.vj & sel_ent.vk;
			op_not: result = ~sel_ent.vj;
			default: result = sel_ent.vj;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			station_busy <= '0;
			cdb_valid <= 1'b0;
		end
		else
		begin
			cdb_valid <= sel_found;   // Broadcast for one cycle
			if (sel_found)
				station_busy[sel_id] <= 1'b0;
			if (rs_write)
				station_busy[res_station_id] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		cdb_tag <= sel_ent.dest;
		cdb_data <= result;
		// Wakeup from the bus
		for (int i = 0; i < num_stations; i++)
		begin
			if (cdb_valid && !ent[i].valid_j && ent[i].qj == cdb_tag)
			begin
				ent[i].vj <= cdb_data;
				ent[i].valid_j <= 1'b1;
			end
			if (cdb_valid && !ent[i].valid_k && ent[i].qk == cdb_tag)
			begin
				ent[i].vk <= cdb_data;
				ent[i].valid_k <= 1'b1;
			end
		end
		if (rs_write)
			ent[res_station_id] <= rs_entry;   // Issue already bypassed this cycle's CDB
	end

endmodule : alu_station

//--- verilog/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
	parameter int queue_depth = 4
)
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input lc3b_types::lc3b_word instr,
	input logic pop,
	output logic head_valid,
	output lc3b_types::lc3b_word head_instr,
	output logic credit_return
);
	import lc3b_types::*;

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	lc3b_word mem [queue_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic do_pop;

	// Wraps at the last slot, depth need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(queue_depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head_instr = mem[rd_ptr];
	assign do_pop = pop && head_valid;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			if (instr_valid)
				wr_ptr <= next_ptr(wr_ptr);   // Fetcher holds a credit, never full here
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + cnt_w'(instr_valid) - cnt_w'(do_pop);
			credit_return <= do_pop;   // One credit back per issued word
		end
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid)
			mem[wr_ptr] <= instr;
	end

endmodule : instr_queue

//--- verilog/issue_control.sv
`timescale 1ns/1ps

module issue_control #(
	parameter int num_stations = 3
)
(
	input lc3b_types::lc3b_word head_instr,
	input logic head_valid,
	input lc3b_types::cdb_t cdb,
	input logic [num_stations-1:0] station_busy,
	input logic rob_full,
	input lc3b_types::lc3b_rob_addr rob_addr,
	input lc3b_types::lc3b_word rob_sr1_value,
	input lc3b_types::lc3b_word rob_sr2_value,
	input logic rob_sr1_valid,
	input logic rob_sr2_valid,
	input lc3b_types::regfile_t sr1_in,
	input lc3b_types::regfile_t sr2_in,
	output lc3b_types::lc3b_reg sr1,
	output lc3b_types::lc3b_reg sr2,
	output lc3b_types::lc3b_rob_addr rob_sr1_read_addr,
	output lc3b_types::lc3b_rob_addr rob_sr2_read_addr,
	output logic issue_fire,
	output lc3b_types::lc3b_opcode rob_opcode,
	output lc3b_types::lc3b_reg rob_dest,
	output lc3b_types::lc3b_rob_addr reg_rob_entry,
	output logic rs_write,
	output logic [$clog2(num_stations)-1:0] res_station_id,
	output lc3b_types::rs_entry_t rs_entry
);
	import lc3b_types::*;

	localparam int id_w = $clog2(num_stations);

	lc3b_opcode opcode;
	lc3b_word imm5;
	logic is_imm;
	logic all_busy;

	// Register value, then CDB this cycle, then finished ROB entry, else wait on tag
	function automatic void resolve(
		input regfile_t src,
		input logic rob_valid,
		input lc3b_word rob_value,
		output logic valid,
		output lc3b_word value,
		output lc3b_rob_addr tag
	);
		valid = 1'b1;
		value = src.data;
		tag = src.rob_entry;
		if (src.busy)
		begin
			if (cdb.valid && cdb.tag == src.rob_entry)
				value = cdb.data;
			else if (rob_valid)
				value = rob_value;
			else
			begin
				valid = 1'b0;
				value = '0;
			end
		end
	endfunction

	assign opcode = lc3b_opcode'(head_instr[15:12]);
	assign sr1 = head_instr[8:6];
	assign sr2 = head_instr[2:0];
	assign is_imm = head_instr[5];
	assign imm5 = {{11{head_instr[4]}}, head_instr[4:0]};

	assign rob_sr1_read_addr = sr1_in.rob_entry;
	assign rob_sr2_read_addr = sr2_in.rob_entry;

	// Structural hazards and empty queue
	assign all_busy = &station_busy;
	assign issue_fire = head_valid && !rob_full && !all_busy;

	assign rs_write = issue_fire;
	assign rob_opcode = opcode;
	assign rob_dest = head_instr[11:9];
	assign reg_rob_entry = rob_addr;

	always_comb
	begin
		res_station_id = '0;
		for (int i = num_stations - 1; i >= 0; i--)
		begin
			if (!station_busy[i])
				res_station_id = id_w'(i);   // Lowest free one survives
		end
	end

	always_comb
	begin
		rs_entry.op = opcode;
		rs_entry.dest = rob_addr;
		resolve(sr1_in, rob_sr1_valid, rob_sr1_value, rs_entry.valid_j, rs_entry.vj, rs_entry.qj);
		if (opcode == op_not)
		begin
			// Only J is an operand
			rs_entry.valid_k = 1'b1;
			rs_entry.vk = '0;
			rs_entry.qk = '0;
		end
		else if (is_imm)
		begin
			rs_entry.valid_k = 1'b1;
			rs_entry.vk = imm5;
			rs_entry.qk = '0;
		end
		else
			resolve(sr2_in, rob_sr2_valid, rob_sr2_value, rs_entry.valid_k, rs_entry.vk, rs_entry.qk);
	end

endmodule : issue_control

//--- verilog/lc3b_types.sv
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_rob_addr;   // Eight ROB entries

	// Full LC-3b opcode map, only the ALU ops reach the stations
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef struct packed {
		logic valid;
		lc3b_rob_addr tag;
		lc3b_word data;
	} cdb_t;

	// One source register as seen by issue
	typedef struct packed {
		logic busy;
		lc3b_rob_addr rob_entry;
		lc3b_word data;
	} regfile_t;

	typedef struct packed {
		lc3b_opcode op;
		lc3b_word vj;
		lc3b_word vk;
		lc3b_rob_addr qj;   // Producer tag while valid_j is low
		lc3b_rob_addr qk;
		logic valid_j;
		logic valid_k;
		lc3b_rob_addr dest;
	} rs_entry_t;

	typedef struct packed {
		lc3b_reg dest;
		lc3b_word value;
	} commit_t;

endpackage

//--- verilog/reg_status.sv
`timescale 1ns/1ps

module reg_status
(
	input logic clk,
	input logic rst,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	output lc3b_types::regfile_t sr1_out,
	output lc3b_types::regfile_t sr2_out,
	input logic issue_fire,
	input lc3b_types::lc3b_reg reg_dest,
	input lc3b_types::lc3b_rob_addr reg_rob_entry,
	input logic commit_valid,
	input lc3b_types::commit_t commit,
	input lc3b_types::lc3b_rob_addr commit_tag
);
	import lc3b_types::*;

	logic [7:0] busy;
	lc3b_rob_addr tag [8];
	lc3b_word data [8];
	logic retire_clears;

	// Only the latest producer may release its register
	assign retire_clears = commit_valid && busy[commit.dest] && (tag[commit.dest] == commit_tag);

	// ROB entry is already freed while its commit is on the port, so forward it here
	function automatic regfile_t read_reg(input lc3b_reg r);
		regfile_t v;
		v.busy = busy[r];
		v.rob_entry = tag[r];
		v.data = data[r];
		if (retire_clears && commit.dest == r)
		begin
			v.busy = 1'b0;
			v.data = commit.value;
		end
		return v;
	endfunction

	always_comb
	begin
		sr1_out = read_reg(sr1);
		sr2_out = read_reg(sr2);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= '0;
			for (int i = 0; i < 8; i++)
			begin
				tag[i] <= '0;
				data[i] <= '0;
			end
		end
		else
		begin
			if (commit_valid)
			begin
				data[commit.dest] <= commit.value;
				if (retire_clears)
					busy[commit.dest] <= 1'b0;
			end
			if (issue_fire)
			begin
				busy[reg_dest] <= 1'b1;   // Later write, wins over the commit clear
				tag[reg_dest] <= reg_rob_entry;
			end
		end
	end

endmodule : reg_status

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
(
	input logic clk,
	input logic rst,
	input lc3b_types::cdb_t cdb,
	input logic issue_fire,
	input lc3b_types::lc3b_opcode rob_opcode,
	input lc3b_types::lc3b_reg rob_dest,
	output lc3b_types::lc3b_rob_addr rob_addr,
	output logic rob_full,
	input lc3b_types::lc3b_rob_addr rob_sr1_read_addr,
	input lc3b_types::lc3b_rob_addr rob_sr2_read_addr,
	output lc3b_types::lc3b_word rob_sr1_value,
	output lc3b_types::lc3b_word rob_sr2_value,
	output logic rob_sr1_valid,
	output logic rob_sr2_valid,
	output logic commit_valid,
	output lc3b_types::commit_t commit,
	output lc3b_types::lc3b_rob_addr commit_tag
);
	import lc3b_types::*;

	logic [7:0] done;
	logic [7:0] has_dest;
	lc3b_reg dest [8];
	lc3b_word value [8];
	lc3b_rob_addr head;
	lc3b_rob_addr tail;
	logic [3:0] count;
	logic retire;

	assign rob_addr = tail;   // Next tag handed to issue
	assign rob_full = (count == 4'd8);
	assign retire = (count != 4'd0) && done[head];

	// Operand reads for issue
	assign rob_sr1_value = value[rob_sr1_read_addr];
	assign rob_sr2_value = value[rob_sr2_read_addr];
	assign rob_sr1_valid = done[rob_sr1_read_addr];
	assign rob_sr2_valid = done[rob_sr2_read_addr];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
			commit_valid <= 1'b0;
		end
		else
		begin
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (issue_fire)
			begin
				done[tail] <= 1'b0;
				tail <= tail + 3'd1;
			end
			if (retire)
				head <= head + 3'd1;
			count <= count + {3'b000, issue_fire} - {3'b000, retire};
			commit_valid <= retire && has_dest[head];
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue_fire)
		begin
			dest[tail] <= rob_dest;
			has_dest[tail] <= (rob_opcode == op_add) || (rob_opcode == op_and) ||
				(rob_opcode == op_not);
		end
		if (cdb.valid)
			value[cdb.tag] <= cdb.data;
		if (retire)
		begin
			commit <= '{dest: dest[head], value: value[head]};
			commit_tag <= head;
		end
	end

endmodule : reorder_buffer

//--- verilog/tomasulo_core.sv
`timescale 1ns/1ps

module tomasulo_core #(
	parameter int queue_depth = 4,
	parameter int num_stations = 3
)
(
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input lc3b_types::lc3b_word instr,
	output logic credit_return,
	output logic commit_valid,
	output lc3b_types::commit_t commit
);
	import lc3b_types::*;

	logic issue_fire;
	logic head_valid;
	lc3b_word head_instr;
	cdb_t cdb;
	logic [num_stations-1:0] station_busy;
	logic rob_full;
	lc3b_rob_addr rob_addr;
	lc3b_word rob_sr1_value;
	lc3b_word rob_sr2_value;
	logic rob_sr1_valid;
	logic rob_sr2_valid;
	regfile_t sr1_in;
	regfile_t sr2_in;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_rob_addr rob_sr1_read_addr;
	lc3b_rob_addr rob_sr2_read_addr;
	lc3b_opcode rob_opcode;
	lc3b_reg rob_dest;
	lc3b_rob_addr reg_rob_entry;
	logic rs_write;
	logic [$clog2(num_stations)-1:0] res_station_id;
	rs_entry_t rs_entry;
	lc3b_rob_addr commit_tag;

	// Port names match the nets, only the odd ones are spelled out
	instr_queue #(.queue_depth(queue_depth)) instr_queue_inst
	(
		.pop(issue_fire),
		.*
	);

	issue_control #(.num_stations(num_stations)) issue_control_inst
	(
		.*
	);

	reg_status reg_status_inst
	(
		.sr1_out(sr1_in),
		.sr2_out(sr2_in),
		.reg_dest(rob_dest),   // Issue destination doubles as the register to mark busy
		.*
	);

	reorder_buffer reorder_buffer_inst
	(
		.*
	);

	alu_station #(.num_stations(num_stations)) alu_station_inst
	(
		.*
	);

endmodule : tomasulo_core
